// ==== Bender.yml ====
package:
  name: malu
  description: "Multi-cycle multiply and divide unit for RISC-V integer instructions"

sources:
  # Design, package first
  - include_dirs:
      - logic
    files:
      - logic/malu_pkg.sv
      - logic/malu_sequencer.sv
      - logic/malu_shift_add_mul.sv
      - logic/malu_divider.sv
      - logic/malu_top.sv

  # Bound checker and testbench
  - target: test
    include_dirs:
      - logic
    files:
      - testbench/malu_assert.sv
      - testbench/malu_tb.sv

// ==== list.f ====
+incdir+logic
logic/malu_pkg.sv
logic/malu_sequencer.sv
logic/malu_shift_add_mul.sv
logic/malu_divider.sv
logic/malu_top.sv
testbench/malu_assert.sv
testbench/malu_tb.sv

// ==== logic/malu_config.svh ====
// Sizes and timing of the multi-cycle arithmetic unit.
// The datapaths are written for a 32-bit word. Changing MALU_XLEN on its
// own is not supported, because the counter width and latency follow from it.
`ifndef MALU_CONFIG_SVH
`define MALU_CONFIG_SVH

// Operand width in bits
`define MALU_XLEN    32

// One iteration per operand bit
`define MALU_STEPS   32

// Must hold the value MALU_STEPS
`define MALU_CNT_W   6

// Edges from the sampling of i_valid in idle to o_ready high
`define MALU_LATENCY 34

`endif

// ==== logic/malu_divider.sv ====
// Restoring divider, one quotient bit per step, MSB first.
// It works on magnitudes and corrects the sign of the result combinationally.
// Division by zero gives all ones and the dividend as remainder, and
// the most negative value divided by -1 overflows to itself with remainder 0.
`timescale 1ns/1ps
`include "malu_config.svh"

module malu_divider (
    input  logic                   clock,
    input  logic                   i_reset,
    input  logic                   i_flush,
    input  logic                   i_load,
    input  logic                   i_step,
    input  malu_pkg::malu_op_e     i_op,            // OP_DIV or OP_REM
    input  logic                   i_div_unsigned,  // divu and remu
    input  logic [`MALU_XLEN-1:0]  i_rs1,           // Dividend
    input  logic [`MALU_XLEN-1:0]  i_rs2,           // Divisor
    output logic [`MALU_XLEN-1:0]  o_result
);
    import malu_pkg::*;

    logic [`MALU_XLEN-1:0]   dividend;   // Turns into the remainder
    logic [`MALU_XLEN-1:0]   quotient;
    logic [2*`MALU_XLEN-2:0] divisor;    // Slides down one bit per step
    logic                    out_sign;   // Negate the selected result

    logic                    op_signed;
    logic                    lhs_neg;
    logic                    rhs_neg;
    logic [`MALU_XLEN-1:0]   rs1_mag;
    logic [`MALU_XLEN-1:0]   rs2_mag;
    logic                    quo_neg;
    logic                    rem_neg;
    logic                    fits;
    logic [`MALU_XLEN-1:0]   result_mag;

    // Operand preparation
    // --------------------
    assign op_signed = !i_div_unsigned;
    assign lhs_neg   = op_signed && i_rs1[`MALU_XLEN-1];
    assign rhs_neg   = op_signed && i_rs2[`MALU_XLEN-1];

    // The magnitude of 0x8000_0000 is itself when read as unsigned
    assign rs1_mag   = lhs_neg ? -i_rs1 : i_rs1;
    assign rs2_mag   = rhs_neg ? -i_rs2 : i_rs2;

    // A zero divisor keeps the quotient positive, so it stays all ones
    assign quo_neg   = (lhs_neg != rhs_neg) && (|i_rs2);
    assign rem_neg   = lhs_neg;                // Remainder follows the dividend

    // Does the shifted divisor fit into what is left of the dividend
    assign fits = (divisor <= {{(`MALU_XLEN-1){1'b0}}, dividend});

    // Iteration
    // --------------------
    always_ff @(posedge clock) begin
        if (i_reset || i_flush) begin
            dividend <= '0;
            quotient <= '0;
            divisor  <= '0;
            out_sign <= 1'b0;
        end else if (i_load) begin
            dividend <= rs1_mag;
            quotient <= '0;
            divisor  <= {rs2_mag, {(`MALU_XLEN-1){1'b0}}};  // Divisor << 31
            out_sign <= (i_op == OP_REM) ? rem_neg : quo_neg;
        end else if (i_step) begin
            if (fits) begin
                dividend <= dividend - divisor[`MALU_XLEN-1:0];
            end
            quotient <= {quotient[`MALU_XLEN-2:0], fits};    // New bit in at LSB
            divisor  <= divisor >> 1;
        end
    end

    // Result
    // --------------------
    assign result_mag = (i_op == OP_REM) ? dividend : quotient;

    // Sign correction on the registers, no extra cycle
    assign o_result   = out_sign ? -result_mag : result_mag;

endmodule

// ==== logic/malu_pkg.sv ====
// Operation and sequencer state encodings shared by the arithmetic unit.
// The value 2'b11 of the operation is unused and is treated as a divide.

package malu_pkg;

    // Operation selector
    typedef enum logic [1:0] {
        OP_MUL = 2'b00,  // Full 64-bit product
        OP_DIV = 2'b01,  // Quotient
        OP_REM = 2'b10   // Remainder
    } malu_op_e;

    // Shared sequencer states
    typedef enum logic [1:0] {
        ST_IDLE = 2'b00,  // Waiting for i_valid
        ST_LOAD = 2'b01,  // Units capture operands
        ST_RUN  = 2'b10,  // One step per cycle
        ST_DONE = 2'b11   // Result held until i_valid drops
    } malu_state_e;

endpackage

// ==== logic/malu_sequencer.sv ====
// Shared control for every unit. It gives one load cycle and then
// MALU_STEPS step cycles, and it holds o_ready until the caller drops i_valid.
// i_flush returns it to idle on the next edge from any state.
`timescale 1ns/1ps
`include "malu_config.svh"

module malu_sequencer (
    input  logic clock,
    input  logic i_reset,
    input  logic i_valid,   // Level, held until o_ready is seen
    input  logic i_flush,   // Pulse
    output logic o_load,
    output logic o_step,
    output logic o_ready
);
    import malu_pkg::*;

    localparam logic [`MALU_CNT_W-1:0] LAST_COUNT = `MALU_STEPS;

    malu_state_e            state;
    malu_state_e            state_next;
    logic [`MALU_CNT_W-1:0] step_cnt;
    logic                   run_done;

    assign run_done = (step_cnt == LAST_COUNT);  // All steps taken

    // Strobes and status
    // --------------------
    assign o_load  = (state == ST_LOAD);
    assign o_step  = (state == ST_RUN) && !run_done;
    assign o_ready = (state == ST_DONE);

    // Next state
    // --------------------
    always_comb begin
        state_next = state;
        case (state)
            ST_IDLE: begin
                if (i_valid) begin
                    state_next = ST_LOAD;
                end
            end
            ST_LOAD: state_next = ST_RUN;
            ST_RUN: begin
                // One extra RUN cycle after the last step gives the fixed latency
                if (run_done) begin
                    state_next = ST_DONE;
                end
            end
            ST_DONE: begin
                if (!i_valid) begin
                    state_next = ST_IDLE;  // Caller has taken the result
                end
            end
            default: state_next = ST_IDLE;
        endcase
    end

    always_ff @(posedge clock) begin
        if (i_reset || i_flush) begin
            state <= ST_IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_ff @(posedge clock) begin
        if (i_reset || i_flush) begin
            step_cnt <= '0;
        end else if (state == ST_LOAD) begin
            step_cnt <= '0;              // Fresh count for each operation
        end else if (o_step) begin
            step_cnt <= step_cnt + 1'b1;
        end
    end

endmodule

// ==== logic/malu_shift_add_mul.sv ====
// Shift-and-add multiplier, one bit of rs2 per step, LSB first.
// i_rs1 and the sign flags are read on every step, so they must stay
// stable from load until the product has been taken.
// The product is only valid once MALU_STEPS steps have been taken.
`timescale 1ns/1ps
`include "malu_config.svh"

module malu_shift_add_mul (
    input  logic                     clock,
    input  logic                     i_reset,
    input  logic                     i_flush,
    input  logic                     i_load,      // Capture rs2, clear accumulator
    input  logic                     i_step,      // One iteration
    input  logic [`MALU_XLEN-1:0]    i_rs1,
    input  logic [`MALU_XLEN-1:0]    i_rs2,
    input  logic                     i_lhs_sign,  // rs1 is signed
    input  logic                     i_rhs_sign,  // rs2 is signed
    output logic [2*`MALU_XLEN-1:0]  o_product
);

    // Datapath registers
    // --------------------
    logic [2*`MALU_XLEN-1:0] acc;        // Partial product, shifts right
    logic [`MALU_XLEN:0]     arg;        // rs2 below a marker bit

    logic                    last_step;
    logic                    sub_last;
    logic [`MALU_XLEN:0]     add_lhs;
    logic [`MALU_XLEN:0]     add_rhs;
    logic [`MALU_XLEN:0]     add_sum;

    // The marker has reached bit 1 when only rs2[31] is left to consume
    assign last_step = (arg[`MALU_XLEN:1] == {{(`MALU_XLEN-1){1'b0}}, 1'b1});

    // A set MSB of a signed multiplier weighs -2^31, so it is subtracted
    assign sub_last  = i_rhs_sign && arg[0] && last_step;

    // Upper half, extended by one bit
    // --------------------
    // For unsigned products the top accumulator bit is a carry and is
    // zero-extended, for signed ones it is the sign
    assign add_lhs = {i_lhs_sign && acc[2*`MALU_XLEN-1], acc[2*`MALU_XLEN-1:`MALU_XLEN]};

    assign add_rhs = arg[0] ? {i_lhs_sign && i_rs1[`MALU_XLEN-1], i_rs1}
                            : '0;              // Nothing to add for a zero bit

    assign add_sum = sub_last ? (add_lhs - add_rhs)
                              : (add_lhs + add_rhs);

    always_ff @(posedge clock) begin
        if (i_reset || i_flush) begin
            acc <= '0;
            arg <= '0;
        end else if (i_load) begin
            acc <= '0;
            arg <= {1'b1, i_rs2};              // Marker above the multiplier
        end else if (i_step) begin
            acc <= {add_sum, acc[`MALU_XLEN-1:1]};   // Add, then shift right
            arg <= {1'b0, arg[`MALU_XLEN:1]};
        end
    end

    assign o_product = acc;

endmodule

// ==== logic/malu_top.sv ====
// Multi-cycle arithmetic unit for mul, mulh, mulhu, mulhsu, div, divu, rem
// and remu. Every operation takes MALU_LATENCY edges from the sampling of i_valid
// to o_ready. Operands, i_op and the sign flags must stay stable while i_valid
// is high. Divide results sit on o_result_lo with o_result_hi zero.
`timescale 1ns/1ps
`include "malu_config.svh"

module malu_top (
    input  logic                   clock,
    input  logic                   i_reset,
    input  logic                   i_valid,         // Level
    input  logic                   i_flush,         // Pulse, abort to idle
    input  malu_pkg::malu_op_e     i_op,
    input  logic                   i_lhs_sign,      // rs1 signed for multiply
    input  logic                   i_rhs_sign,      // rs2 signed for multiply
    input  logic                   i_div_unsigned,  // Unsigned divide or remainder
    input  logic [`MALU_XLEN-1:0]  i_rs1,
    input  logic [`MALU_XLEN-1:0]  i_rs2,
    output logic                   o_ready,
    output logic [`MALU_XLEN-1:0]  o_result_hi,
    output logic [`MALU_XLEN-1:0]  o_result_lo
);
    import malu_pkg::*;

    logic                    load;
    logic                    step;
    logic [2*`MALU_XLEN-1:0] product;
    logic [`MALU_XLEN-1:0]   div_result;
    logic                    is_mul;

    malu_sequencer u_sequencer (
        .clock   (clock),
        .i_reset (i_reset),
        .i_valid (i_valid),
        .i_flush (i_flush),
        .o_load  (load),
        .o_step  (step),
        .o_ready (o_ready)
    );

    // Both units run every operation, the result mux picks one
    malu_shift_add_mul u_mul (
        .clock      (clock),
        .i_reset    (i_reset),
        .i_flush    (i_flush),
        .i_load     (load),
        .i_step     (step),
        .i_rs1      (i_rs1),
        .i_rs2      (i_rs2),
        .i_lhs_sign (i_lhs_sign),
        .i_rhs_sign (i_rhs_sign),
        .o_product  (product)
    );

    malu_divider u_div (
        .clock          (clock),
        .i_reset        (i_reset),
        .i_flush        (i_flush),
        .i_load         (load),
        .i_step         (step),
        .i_op           (i_op),
        .i_div_unsigned (i_div_unsigned),
        .i_rs1          (i_rs1),
        .i_rs2          (i_rs2),
        .o_result       (div_result)
    );

    // Result select
    // --------------------
    assign is_mul      = (i_op == OP_MUL);
    assign o_result_hi = is_mul ? product[2*`MALU_XLEN-1:`MALU_XLEN] : '0;
    assign o_result_lo = is_mul ? product[`MALU_XLEN-1:0] : div_result;

endmodule

// ==== testbench/malu_assert.sv ====
// Concurrent checks bound into every malu_top instance.
// Expected results come from the input ports, which the caller keeps stable
// while i_valid is high. Every failure is also counted in fail_count.
`timescale 1ns/1ps
`include "malu_config.svh"

module malu_assert (
    input logic                   clock,
    input logic                   i_reset,
    input logic                   i_valid,
    input logic                   i_flush,
    input malu_pkg::malu_op_e     i_op,
    input logic                   i_lhs_sign,
    input logic                   i_rhs_sign,
    input logic                   i_div_unsigned,
    input logic [`MALU_XLEN-1:0]  i_rs1,
    input logic [`MALU_XLEN-1:0]  i_rs2,
    input logic                   o_ready,
    input logic [`MALU_XLEN-1:0]  o_result_hi,
    input logic [`MALU_XLEN-1:0]  o_result_lo
);
    import malu_pkg::*;

    localparam int                    LAT      = `MALU_LATENCY;
    localparam logic [`MALU_XLEN-1:0] MOST_NEG = {1'b1, {(`MALU_XLEN-1){1'b0}}};

    int unsigned                    fail_count = 0;
    logic signed [2*`MALU_XLEN-1:0] lhs_ext;
    logic signed [2*`MALU_XLEN-1:0] rhs_ext;
    logic [`MALU_XLEN-1:0]          quo;
    logic [`MALU_XLEN-1:0]          rem;
    logic [2*`MALU_XLEN-1:0]        expected;

    // Reference model
    // --------------------
    always_comb begin
        lhs_ext = {{`MALU_XLEN{i_lhs_sign && i_rs1[`MALU_XLEN-1]}}, i_rs1};
        rhs_ext = {{`MALU_XLEN{i_rhs_sign && i_rs2[`MALU_XLEN-1]}}, i_rs2};
        if (i_rs2 == '0) begin
            quo = '1;                               // RISC-V divide by zero
            rem = i_rs1;
        end else if (!i_div_unsigned && i_rs1 == MOST_NEG && i_rs2 == '1) begin
            quo = MOST_NEG;                         // Signed overflow
            rem = '0;
        end else if (i_div_unsigned) begin
            quo = i_rs1 / i_rs2;
            rem = i_rs1 % i_rs2;
        end else begin
            quo = $signed(i_rs1) / $signed(i_rs2);  // Truncates toward zero
            rem = $signed(i_rs1) % $signed(i_rs2);
        end
        if (i_op == OP_MUL) begin
            expected = lhs_ext * rhs_ext;
        end else if (i_op == OP_REM) begin
            expected = {{`MALU_XLEN{1'b0}}, rem};
        end else begin
            expected = {{`MALU_XLEN{1'b0}}, quo};
        end
    end

    // Properties
    // --------------------
    assert property (@(posedge clock) (i_reset || i_flush) |=>
                     (!o_ready && o_result_hi == '0 && o_result_lo == '0))
        else begin
            $error("o_ready or result not cleared after reset or flush");
            fail_count++;
        end

    assert property (@(posedge clock) disable iff (i_reset || i_flush)
                     (!i_valid && !o_ready) |=> !o_ready)
        else begin
            $error("o_ready rose with no operation requested");
            fail_count++;
        end

    assert property (@(posedge clock) disable iff (i_reset || i_flush)
                     $rose(i_valid) |=> !o_ready [*LAT] ##1 o_ready)
        else begin
            $error("o_ready did not rise exactly %0d edges after the request", LAT);
            fail_count++;
        end

    assert property (@(posedge clock) disable iff (i_reset || i_flush)
                     (o_ready && i_valid) |=>
                     (o_ready && $stable(o_result_hi) && $stable(o_result_lo)))
        else begin
            $error("o_ready or result not held while i_valid stayed high");
            fail_count++;
        end

    assert property (@(posedge clock) disable iff (i_reset || i_flush)
                     (o_ready && i_valid) |-> ({o_result_hi, o_result_lo} == expected))
        else begin
            $error("result %h differs from model %h", {o_result_hi, o_result_lo}, expected);
            fail_count++;
        end

endmodule

bind malu_top malu_assert u_assert (.*);

// ==== testbench/malu_tb.sv ====
// Directed and random tests for malu_top.
// The bound malu_assert checker does the protocol, latency and result checks.
// This module drives the operations and reports each test.
// All random operands follow from one fixed seed.
`timescale 1ns/1ps
`include "malu_config.svh"

module malu_tb;
    import malu_pkg::*;

    localparam int XLEN       = `MALU_XLEN;
    localparam int LATENCY    = `MALU_LATENCY;
    localparam int WAIT_LIMIT = 4 * `MALU_LATENCY;  // Cycles before a wait gives up
    localparam int RAND_COUNT = 8;                  // Random tests per mode

    logic            clock;
    logic            i_reset;
    logic            i_valid;
    logic            i_flush;
    malu_op_e        i_op;
    logic            i_lhs_sign;
    logic            i_rhs_sign;
    logic            i_div_unsigned;
    logic [XLEN-1:0] i_rs1;
    logic [XLEN-1:0] i_rs2;
    logic            o_ready;
    logic [XLEN-1:0] o_result_hi;
    logic [XLEN-1:0] o_result_lo;

    int              tests_run;
    int              tests_failed;
    int              test_errors;                   // Failed checks in the current test

    malu_top UUT (
        .clock          (clock),
        .i_reset        (i_reset),
        .i_valid        (i_valid),
        .i_flush        (i_flush),
        .i_op           (i_op),
        .i_lhs_sign     (i_lhs_sign),
        .i_rhs_sign     (i_rhs_sign),
        .i_div_unsigned (i_div_unsigned),
        .i_rs1          (i_rs1),
        .i_rs2          (i_rs2),
        .o_ready        (o_ready),
        .o_result_hi    (o_result_hi),
        .o_result_lo    (o_result_lo)
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;                  // 4 ns period
    end

    // Helpers
    // --------------------
    task automatic report_test(input string name);
        tests_run++;
        if (test_errors == 0) begin
            $display("PASS %s", name);
        end else begin
            tests_failed++;
            $display("FAIL %s with %0d failed checks", name, test_errors);
        end
        test_errors = 0;
    endtask

    task automatic expect_not_ready(input string name, input int cycles);
        int n;
        n = 0;
        while (n < cycles) begin
            @(negedge clock);
            if (o_ready) begin
                $display("%s: o_ready was high with no operation running", name);
                test_errors++;
            end
            n++;
        end
    endtask

    // One full operation, held for a few cycles after o_ready
    task automatic run_op(input string name, input malu_op_e op, input logic lhs_s,
                          input logic rhs_s, input logic div_u,
                          input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
        logic [2*XLEN-1:0] expected;
        logic [2*XLEN-1:0] first_result;
        int                edges;
        int                hold;
        hold = 1 + ($urandom % 3);
        @(posedge clock);
        i_op           <= op;
        i_lhs_sign     <= lhs_s;
        i_rhs_sign     <= rhs_s;
        i_div_unsigned <= div_u;
        i_rs1          <= a;
        i_rs2          <= b;
        i_valid        <= 1'b1;
        @(posedge clock);                           // Sampling edge
        edges = 0;
        @(negedge clock);
        while (!o_ready && edges < WAIT_LIMIT) begin
            @(posedge clock);
            edges++;
            @(negedge clock);
        end
        if (!o_ready) begin
            $display("%s: o_ready did not rise within %0d cycles", name, WAIT_LIMIT);
            test_errors++;
        end else begin
            if (edges != LATENCY) begin
                $display("ERROR %s latency: expected %0d, actual %0d", name, LATENCY, edges);
                test_errors++;
            end
            expected     = UUT.u_assert.expected;   // Model in the bound checker
            first_result = {o_result_hi, o_result_lo};
            if (first_result !== expected) begin
                $display("ERROR %s: expected %h, actual %h", name, expected, first_result);
                test_errors++;
            end
            repeat (hold) begin
                @(posedge clock);
                @(negedge clock);
                if (!o_ready || {o_result_hi, o_result_lo} !== first_result) begin
                    $display("%s: o_ready or the result changed while i_valid was held",
                             name);
                    test_errors++;
                end
            end
        end
        @(posedge clock);
        i_valid <= 1'b0;
        edges = 0;
        @(negedge clock);
        while (o_ready && edges < WAIT_LIMIT) begin
            @(negedge clock);
            edges++;
        end
        if (o_ready) begin
            $display("%s: o_ready stayed high after i_valid dropped", name);
            test_errors++;
        end
        report_test(name);
    endtask

    // Start an operation and abort it after run_cycles edges
    task automatic flush_op(input string name, input malu_op_e op,
                            input logic [XLEN-1:0] a, input logic [XLEN-1:0] b,
                            input int run_cycles);
        @(posedge clock);
        i_op           <= op;
        i_lhs_sign     <= 1'b1;
        i_rhs_sign     <= 1'b1;
        i_div_unsigned <= 1'b0;
        i_rs1          <= a;
        i_rs2          <= b;
        i_valid        <= 1'b1;
        repeat (run_cycles) @(posedge clock);
        i_flush <= 1'b1;
        i_valid <= 1'b0;
        @(posedge clock);
        i_flush <= 1'b0;
        @(negedge clock);
        if ({o_result_hi, o_result_lo} !== '0) begin
            $display("ERROR %s: expected %h, actual %h", name, {2*XLEN{1'b0}},
                     {o_result_hi, o_result_lo});
            test_errors++;
        end
        expect_not_ready(name, LATENCY + 8);
        report_test(name);
    endtask

    // Test sequence
    // --------------------
    initial begin
        int              mode;
        int              k;
        logic [XLEN-1:0] divisor;
        malu_op_e        op;
        string           tag;
        void'($urandom(32'h168e_cbd1));
        i_reset        = 1'b1;
        i_valid        = 1'b0;
        i_flush        = 1'b0;
        i_op           = OP_MUL;
        i_lhs_sign     = 1'b0;
        i_rhs_sign     = 1'b0;
        i_div_unsigned = 1'b0;
        i_rs1          = '0;
        i_rs2          = '0;
        tests_run      = 0;
        tests_failed   = 0;
        test_errors    = 0;
        repeat (8) @(posedge clock);
        i_reset <= 1'b0;

        expect_not_ready("idle_after_reset", 10);
        report_test("idle_after_reset");

        for (mode = 0; mode < 4; mode++) begin       // Bit 1 rs1 signed, bit 0 rs2 signed
            for (k = 0; k < RAND_COUNT; k++) begin
                run_op($sformatf("mul_%s%s_rand_%0d", mode[1] ? "s" : "u",
                                 mode[0] ? "s" : "u", k),
                       OP_MUL, mode[1], mode[0], 1'b0, $urandom, $urandom);
            end
        end

        for (mode = 0; mode < 4; mode++) begin       // Bit 1 unsigned, bit 0 remainder
            op  = mode[0] ? OP_REM : OP_DIV;
            tag = mode[0] ? "rem" : "div";
            if (mode[1]) begin
                tag = {tag, "u"};
            end
            for (k = 0; k < RAND_COUNT; k++) begin
                divisor = $urandom >> ($urandom % XLEN);  // Spread of divisor sizes
                if ($urandom % 2) begin
                    divisor = -divisor;                   // Negative or large unsigned
                end
                run_op($sformatf("%s_rand_%0d", tag, k), op, 1'b0, 1'b0, mode[1],
                       $urandom, divisor);
            end
        end

        run_op("div_by_zero", OP_DIV, 1'b0, 1'b0, 1'b0, 32'h1234_5678, 32'h0);
        run_op("rem_by_zero", OP_REM, 1'b0, 1'b0, 1'b0, 32'h8765_4321, 32'h0);
        run_op("divu_by_zero", OP_DIV, 1'b0, 1'b0, 1'b1, 32'h8765_4321, 32'h0);
        run_op("remu_by_zero", OP_REM, 1'b0, 1'b0, 1'b1, 32'h1234_5678, 32'h0);
        run_op("div_overflow", OP_DIV, 1'b0, 1'b0, 1'b0, 32'h8000_0000, 32'hffff_ffff);
        run_op("rem_overflow", OP_REM, 1'b0, 1'b0, 1'b0, 32'h8000_0000, 32'hffff_ffff);
        run_op("divu_min_by_ones", OP_DIV, 1'b0, 1'b0, 1'b1, 32'h8000_0000, 32'hffff_ffff);
        run_op("mul_zero", OP_MUL, 1'b1, 1'b1, 1'b0, 32'h0, 32'hdead_beef);
        run_op("mul_ones_ss", OP_MUL, 1'b1, 1'b1, 1'b0, 32'hffff_ffff, 32'hffff_ffff);
        run_op("mul_ones_uu", OP_MUL, 1'b0, 1'b0, 1'b0, 32'hffff_ffff, 32'hffff_ffff);
        run_op("mul_ones_su", OP_MUL, 1'b1, 1'b0, 1'b0, 32'hffff_ffff, 32'hffff_ffff);
        run_op("mul_min_min_ss", OP_MUL, 1'b1, 1'b1, 1'b0, 32'h8000_0000, 32'h8000_0000);

        flush_op("flush_mul", OP_MUL, $urandom, $urandom, 12);
        run_op("after_flush_mul", OP_MUL, 1'b1, 1'b0, 1'b0, $urandom, $urandom);
        flush_op("flush_div", OP_DIV, $urandom, $urandom, 30);
        run_op("after_flush_div", OP_DIV, 1'b0, 1'b0, 1'b0, $urandom, $urandom);

        $display("Tests run %0d, failed %0d, assertion failures %0d",
                 tests_run, tests_failed, UUT.u_assert.fail_count);
        if (tests_failed == 0 && UUT.u_assert.fail_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
